/* src/onewire_pkg.sv */
package onewire_pkg;

  // ------------------------------------------------------------------
  // slot kinds handed from the sequencer to the slot engine
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    SLOT_RESET  = 2'd0,                    // reset pulse + presence sample
    SLOT_WRITE0 = 2'd1,                    // long low
    SLOT_WRITE1 = 2'd2,                    // short low
    SLOT_READ   = 2'd3                     // short low, then sample
  } slot_op_t;

  // ------------------------------------------------------------------
  // bus timing in microseconds
  // ------------------------------------------------------------------
  localparam int T_RESET_LOW_US     = 500; // master reset low
  localparam int T_PRESENCE_US      = 100; // release to presence sample
  localparam int T_RESET_RECOVER_US = 400; // rest of the presence window

  localparam int T_WRITE_SLOT_US    = 80;  // long part of a write slot
  localparam int T_LOW_PULSE_US     = 1;   // start pulse
  localparam int T_READ_SAMPLE_US   = 10;  // release to read sample
  localparam int T_READ_RECOVER_US  = 55;  // rest of the read slot

  localparam int US_CNT_W           = 20;  // covers the 750 ms wait

  // ------------------------------------------------------------------
  // DS18B20 commands
  // ------------------------------------------------------------------
  localparam logic [7:0] CMD_SKIP_ROM     = 8'hCC;
  localparam logic [7:0] CMD_CONVERT_T    = 8'h44;
  localparam logic [7:0] CMD_READ_SCRATCH = 8'hBE;

  localparam int SCRATCH_BITS = 16;        // temperature LSB + MSB

  // scratchpad temperature word, 1/16 degree per LSB
  typedef struct packed {
    logic [4:0] sign_ext;                  // copies of the sign
    logic [6:0] int_part;                  // whole degrees
    logic [3:0] frac;                      // sixteenths
  } scratch_fields_t;

  // one word, read as a number or split into fields
  typedef union packed {
    logic [15:0]     raw;                  // two's complement
    scratch_fields_t fields;
  } scratch_word_t;

endpackage

/* src/onewire_slot_engine.sv */
`timescale 1ns/1ps

module onewire_slot_engine import onewire_pkg::*; #(
  parameter int CLKS_PER_US = 50
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     slot_stb,
  input  slot_op_t slot_op,
  input  logic     bus_in,
  output logic     slot_ack,
  output logic     rd_bit,
  output logic     presence,
  output logic     bus_low,
  output logic     us_tick
);

  localparam int DIV_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOW,
    ST_RELEASE,
    ST_SAMPLE,
    ST_RECOVER
  } phase_t;

  phase_t              state;
  slot_op_t            op_q;               // op of the running slot
  logic [DIV_W-1:0]    div_cnt;
  logic [US_CNT_W-1:0] us_cnt;             // ticks seen in this phase
  logic [US_CNT_W-1:0] phase_len;
  logic                phase_done;
  logic                bus_meta;
  logic                bus_sync;

  // ------------------------------------------------------------------
  // microsecond tick, free running
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      us_tick <= 1'b0;
    end
    else if (div_cnt == DIV_W'(CLKS_PER_US - 1))
    begin
      div_cnt <= '0;
      us_tick <= 1'b1;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
      us_tick <= 1'b0;
    end
  end

  // released line idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bus_meta <= 1'b1;
      bus_sync <= 1'b1;
    end
    else
    begin
      bus_meta <= bus_in;
      bus_sync <= bus_meta;
    end
  end

  // length of the current phase, per slot kind
  always_comb
  begin
    phase_len = '0;
    case (state)
      ST_LOW:
        case (op_q)
          SLOT_RESET:  phase_len = US_CNT_W'(T_RESET_LOW_US);
          SLOT_WRITE0: phase_len = US_CNT_W'(T_WRITE_SLOT_US);
          default:     phase_len = US_CNT_W'(T_LOW_PULSE_US);
        endcase
      ST_RELEASE:
        case (op_q)
          SLOT_RESET:  phase_len = US_CNT_W'(T_PRESENCE_US);
          SLOT_WRITE0: phase_len = US_CNT_W'(T_LOW_PULSE_US);
          SLOT_WRITE1: phase_len = US_CNT_W'(T_WRITE_SLOT_US);
          default:     phase_len = US_CNT_W'(T_READ_SAMPLE_US);
        endcase
      ST_RECOVER:
        if (op_q == SLOT_RESET)
          phase_len = US_CNT_W'(T_RESET_RECOVER_US);
        else
          phase_len = US_CNT_W'(T_READ_RECOVER_US);
      default:
        phase_len = '0;
    endcase
  end

  // one extra tick so a phase never runs short of its length
  assign phase_done = us_tick && (us_cnt == phase_len);

  // ------------------------------------------------------------------
  // slot phase FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      op_q     <= SLOT_RESET;
      us_cnt   <= '0;
      bus_low  <= 1'b0;
      slot_ack <= 1'b0;
      rd_bit   <= 1'b0;
      presence <= 1'b0;
    end
    else
    begin
      slot_ack <= 1'b0;
      if (us_tick)
        us_cnt <= us_cnt + 1'b1;
      case (state)
        ST_IDLE:
          if (slot_stb && !slot_ack)       // no start in our own ack cycle
          begin
            op_q    <= slot_op;
            us_cnt  <= '0;
            bus_low <= 1'b1;
            state   <= ST_LOW;
          end
        ST_LOW:
          if (phase_done)
          begin
            us_cnt  <= '0;
            bus_low <= 1'b0;               // release, pull-up takes over
            state   <= ST_RELEASE;
          end
        ST_RELEASE:
          if (phase_done)
          begin
            us_cnt <= '0;
            if (op_q == SLOT_WRITE0 || op_q == SLOT_WRITE1)
            begin
              slot_ack <= 1'b1;
              state    <= ST_IDLE;
            end
            else
              state <= ST_SAMPLE;
          end
        ST_SAMPLE:
        begin
          if (op_q == SLOT_RESET)
            presence <= ~bus_sync;         // device pulls low
          else
            rd_bit <= bus_sync;
          us_cnt <= '0;
          state  <= ST_RECOVER;
        end
        ST_RECOVER:
          if (phase_done)
          begin
            slot_ack <= 1'b1;
            state    <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* src/ds18b20_sequencer.sv */
`timescale 1ns/1ps

module ds18b20_sequencer import onewire_pkg::*; #(
  parameter int CONV_WAIT_US = 750000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          slot_ack,
  input  logic          rd_bit,
  input  logic          presence,
  input  logic          us_tick,
  output logic          slot_stb,
  output slot_op_t      slot_op,
  output logic          raw_valid,
  output scratch_word_t raw_word
);

  localparam int BIT_W = $clog2(SCRATCH_BITS);

  typedef enum logic [1:0] {
    PH_RESET,
    PH_WRITE,
    PH_WAIT,
    PH_READ
  } seq_phase_t;

  seq_phase_t          phase;
  logic [1:0]          cmd_idx;            // 0..3 -> CC 44 CC BE
  logic [7:0]          shift;              // command byte, LSB goes out first
  logic [BIT_W-1:0]    bit_cnt;
  logic [US_CNT_W-1:0] wait_cnt;
  logic [7:0]          cur_byte;
  logic [7:0]          next_byte;

  function automatic logic [7:0] cmd_byte(input logic [1:0] idx);
    case (idx)
      2'd1:    return CMD_CONVERT_T;
      2'd3:    return CMD_READ_SCRATCH;
      default: return CMD_SKIP_ROM;
    endcase
  endfunction

  function automatic slot_op_t bit_op(input logic b);
    return b ? SLOT_WRITE1 : SLOT_WRITE0;
  endfunction

  assign cur_byte  = cmd_byte(cmd_idx);
  assign next_byte = cmd_byte(cmd_idx + 2'd1);

  // ------------------------------------------------------------------
  // transaction FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase     <= PH_RESET;
      cmd_idx   <= 2'd0;
      shift     <= '0;
      bit_cnt   <= '0;
      wait_cnt  <= '0;
      slot_stb  <= 1'b0;
      slot_op   <= SLOT_RESET;
      raw_valid <= 1'b0;
    end
    else
    begin
      raw_valid <= 1'b0;
      case (phase)
        PH_RESET:
          if (!slot_stb)
          begin
            slot_stb <= 1'b1;              // first request after reset
            slot_op  <= SLOT_RESET;
          end
          else if (slot_ack && presence)
          begin
            shift   <= cur_byte;
            bit_cnt <= '0;
            slot_op <= bit_op(cur_byte[0]);
            phase   <= PH_WRITE;
          end                              // no presence: same reset again
        PH_WRITE:
          if (slot_ack)
          begin
            if (bit_cnt == BIT_W'(7))
            begin
              bit_cnt <= '0;
              cmd_idx <= cmd_idx + 2'd1;
              case (cmd_idx)
                2'd1:
                begin
                  slot_stb <= 1'b0;        // bus idle during conversion
                  wait_cnt <= '0;
                  phase    <= PH_WAIT;
                end
                2'd3:
                begin
                  slot_op <= SLOT_READ;
                  phase   <= PH_READ;
                end
                default:
                begin
                  shift   <= next_byte;    // skip rom done, next command
                  slot_op <= bit_op(next_byte[0]);
                end
              endcase
            end
            else
            begin
              shift   <= shift >> 1;
              bit_cnt <= bit_cnt + 1'b1;
              slot_op <= bit_op(shift[1]);
            end
          end
        PH_WAIT:
          if (us_tick)
          begin
            if (wait_cnt == US_CNT_W'(CONV_WAIT_US - 1))
            begin
              slot_stb <= 1'b1;
              slot_op  <= SLOT_RESET;
              phase    <= PH_RESET;
            end
            else
              wait_cnt <= wait_cnt + 1'b1;
          end
        PH_READ:
          if (slot_ack)
          begin
            if (bit_cnt == BIT_W'(SCRATCH_BITS - 1))
            begin
              bit_cnt   <= '0;
              raw_valid <= 1'b1;           // word complete this cycle
              slot_op   <= SLOT_RESET;
              phase     <= PH_RESET;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
        default:
          phase <= PH_RESET;
      endcase
    end
  end

  // read bits arrive LSB first, shift in from the top
  always_ff @(posedge clk)
  begin
    if (phase == PH_READ && slot_ack)
      raw_word.raw <= {rd_bit, raw_word.raw[15:1]};
  end

endmodule

/* src/temp_formatter.sv */
`timescale 1ns/1ps

module temp_formatter import onewire_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          raw_valid,
  input  scratch_word_t raw_word,
  output logic [15:0]   temperature,
  output logic          temp_valid
);

  logic          neg;
  scratch_word_t mag;
  logic [7:0]    frac_x10;
  logic          clamp;
  logic [3:0]    tens;
  logic [3:0]    units;
  logic [3:0]    tenths;

  // ------------------------------------------------------------------
  // magnitude and decimal split
  // ------------------------------------------------------------------
  assign neg = raw_word.raw[15];

  always_comb
  begin
    if (neg)
      mag.raw = ~raw_word.raw + 16'd1;     // two's complement negate
    else
      mag.raw = raw_word.raw;
  end

  assign frac_x10 = {4'd0, mag.fields.frac} * 8'd10;

  // anything past 99 degrees, including -128, saturates
  assign clamp = (mag.fields.sign_ext != 5'd0) || (mag.fields.int_part > 7'd99);

  always_comb
  begin
    if (clamp)
    begin
      tens   = 4'd9;
      units  = 4'd9;
      tenths = 4'd9;
    end
    else
    begin
      tens   = 4'(mag.fields.int_part / 7'd10);
      units  = 4'(mag.fields.int_part % 7'd10);
      tenths = frac_x10[7:4];              // x10/16, rounded down
    end
  end

  // ------------------------------------------------------------------
  // output register
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      temperature <= 16'h0000;
      temp_valid  <= 1'b0;
    end
    else
    begin
      temp_valid <= raw_valid;
      if (raw_valid)
        temperature <= {3'b000, neg, tens, units, tenths};
    end
  end

endmodule

/* src/ds18b20_reader.sv */
`timescale 1ns/1ps

module ds18b20_reader import onewire_pkg::*; #(
  parameter int CLKS_PER_US  = 50,
  parameter int CONV_WAIT_US = 750000
) (
  input  logic        clk,
  input  logic        rst_n,
  inout  wire         one_wire,
  output logic [15:0] temperature,
  output logic        temp_valid
);

  logic          slot_stb;
  slot_op_t      slot_op;
  logic          slot_ack;
  logic          rd_bit;
  logic          presence;
  logic          bus_low;
  logic          us_tick;
  logic          raw_valid;
  scratch_word_t raw_word;

  // open drain, external pull-up holds the line high
  assign one_wire = bus_low ? 1'b0 : 1'bz;

  onewire_slot_engine #(
    .CLKS_PER_US (CLKS_PER_US)
  ) slot_engine_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .slot_stb (slot_stb),
    .slot_op  (slot_op),
    .bus_in   (one_wire),
    .slot_ack (slot_ack),
    .rd_bit   (rd_bit),
    .presence (presence),
    .bus_low  (bus_low),
    .us_tick  (us_tick)
  );

  ds18b20_sequencer #(
    .CONV_WAIT_US (CONV_WAIT_US)
  ) sequencer_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .slot_ack  (slot_ack),
    .rd_bit    (rd_bit),
    .presence  (presence),
    .us_tick   (us_tick),
    .slot_stb  (slot_stb),
    .slot_op   (slot_op),
    .raw_valid (raw_valid),
    .raw_word  (raw_word)
  );

  temp_formatter formatter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .raw_valid   (raw_valid),
    .raw_word    (raw_word),
    .temperature (temperature),
    .temp_valid  (temp_valid)
  );

endmodule

/* tb/ds18b20_model.sv */
`timescale 1ns/1ps

module ds18b20_model #(
  parameter int US_NS = 160                // one bus microsecond in ns
) (
  inout  wire         one_wire,
  input  logic        presence_en,
  input  logic [15:0] temp_raw,
  output int          cmd_errors
);

  logic [7:0]  expect_cmd [4];
  logic        drive_low;
  logic [7:0]  rx_byte;
  int          rx_bits;
  int          cmd_pos;                    // position in CC 44 CC BE
  int          read_left;
  logic [15:0] tx_word;
  realtime     t_fall;

  assign one_wire = drive_low ? 1'b0 : 1'bz;

  // presence pulse 15 us after release, 120 us long
  task automatic answer_reset();
    rx_bits = 0;
    if (presence_en)
    begin
      #(15 * US_NS);
      drive_low = 1'b1;
      #(120 * US_NS);
      drive_low = 1'b0;
    end
  endtask

  task automatic take_bit(input logic b);
    rx_byte = {b, rx_byte[7:1]};           // LSB first
    rx_bits++;
    if (rx_bits == 8)
    begin
      rx_bits = 0;
      if (rx_byte !== expect_cmd[cmd_pos])
      begin
        $display("model: got command byte %h where %h belongs", rx_byte, expect_cmd[cmd_pos]);
        cmd_errors++;
      end
      if (cmd_pos == 3)
      begin
        tx_word   = temp_raw;              // scratchpad bytes 0 and 1
        read_left = 16;
      end
      cmd_pos = (cmd_pos + 1) % 4;
    end
  endtask

  task automatic send_bit();
    read_left--;
    if (!tx_word[0])
    begin
      drive_low = 1'b1;                    // stretch the master low
      #(30 * US_NS);
      drive_low = 1'b0;
    end
    tx_word = tx_word >> 1;
  endtask

  // ------------------------------------------------------------------
  // slot decoder, one pass per master falling edge
  // ------------------------------------------------------------------
  initial
  begin
    expect_cmd = '{8'hCC, 8'h44, 8'hCC, 8'hBE};
    drive_low  = 1'b0;
    rx_byte    = 8'h00;
    rx_bits    = 0;
    cmd_pos    = 0;
    read_left  = 0;
    tx_word    = 16'h0000;
    cmd_errors = 0;
    forever
    begin
      @(negedge one_wire);
      t_fall = $realtime;
      if (read_left > 0)
        send_bit();
      else
      begin
        #(30 * US_NS);
        if (one_wire === 1'b1)
          take_bit(1'b1);
        else
        begin
          @(posedge one_wire);
          if ($realtime - t_fall > 400.0 * US_NS)
            answer_reset();                // long low is a reset
          else
            take_bit(1'b0);
        end
      end
    end
  end

endmodule

/* tb/reader_checker.sv */
`timescale 1ns/1ps

module reader_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        temp_valid,
  input  logic [15:0] temperature,
  input  logic        expect_reading,
  input  logic [15:0] expected,
  input  int          test_id,
  input  logic        window_end,
  output int          pass_count,
  output int          fail_count
);

  logic stray_seen;                        // reading during a quiet window

  initial
  begin
    pass_count = 0;
    fail_count = 0;
    stray_seen = 1'b0;
  end

  always @(posedge clk)
  begin
    if (rst_n && temp_valid)
    begin
      if (!expect_reading)
      begin
        $display("test %0d: reading %h published while presence was off", test_id, temperature);
        stray_seen = 1'b1;
      end
      else if (temperature !== expected)
      begin
        $display("** Error at %0d ns: temperature = %h, expected %h",
                 $time, temperature, expected);
        fail_count++;
      end
      else
      begin
        $display("test %0d: temperature %h ok", test_id, temperature);
        pass_count++;
      end
    end
    if (window_end)
    begin
      if (stray_seen)
      begin
        $display("test %0d: failed, a reading appeared without presence", test_id);
        fail_count++;
      end
      else
      begin
        $display("test %0d: no reading without presence, ok", test_id);
        pass_count++;
      end
      stray_seen = 1'b0;
    end
  end

endmodule

/* tb/reader_sva.sv */
`timescale 1ns/1ps

module reader_sva import onewire_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     slot_stb,
  input slot_op_t slot_op,
  input logic     slot_ack,
  input logic     bus_low
);

  ack_inside_stb: assert property (@(posedge clk) disable iff (!rst_n) slot_ack |-> slot_stb)
    else $error("slot_ack high while slot_stb is low");

  op_held: assert property (@(posedge clk) disable iff (!rst_n)
    (slot_stb && !slot_ack) |=> $stable(slot_op))
    else $error("slot_op changed before slot_ack");

  ack_single: assert property (@(posedge clk) disable iff (!rst_n) slot_ack |=> !slot_ack)
    else $error("slot_ack longer than one cycle");

  bus_free_in_reset: assert property (@(posedge clk) !rst_n |-> !bus_low)
    else $error("bus_low asserted during reset");

endmodule

bind onewire_slot_engine reader_sva reader_sva_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .slot_stb (slot_stb),
  .slot_op  (slot_op),
  .slot_ack (slot_ack),
  .bus_low  (bus_low)
);

/* tb/tb_ds18b20_reader.sv */
`timescale 1ns/1ps

module tb_ds18b20_reader;

  localparam int CLKS_PER_US    = 4;
  localparam int CONV_WAIT_US   = 300;
  localparam int NUM_ROWS       = 10;
  localparam int TIMEOUT_CYCLES = 60000;   // about two full readings
  localparam int WINDOW_CYCLES  = 40000;   // longer than one reading

  typedef struct {
    logic [15:0] raw;
    logic        presence;
    logic [15:0] expected;
  } row_t;

  row_t        table_rows [NUM_ROWS];
  logic        clk;
  logic        rst_n;
  wire         one_wire;
  logic [15:0] temperature;
  logic        temp_valid;
  logic        presence_en;
  logic [15:0] model_raw;
  logic        expect_reading;
  logic [15:0] expected;
  int          test_id;
  logic        window_end;
  int          pass_count;
  int          fail_count;
  int          cmd_errors;
  logic        timed_out;
  logic        got_reading;

  pullup (one_wire);

  ds18b20_reader #(
    .CLKS_PER_US  (CLKS_PER_US),
    .CONV_WAIT_US (CONV_WAIT_US)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .one_wire    (one_wire),
    .temperature (temperature),
    .temp_valid  (temp_valid)
  );

  ds18b20_model #(
    .US_NS (CLKS_PER_US * 40)
  ) model_i (
    .one_wire    (one_wire),
    .presence_en (presence_en),
    .temp_raw    (model_raw),
    .cmd_errors  (cmd_errors)
  );

  reader_checker checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .temp_valid     (temp_valid),
    .temperature    (temperature),
    .expect_reading (expect_reading),
    .expected       (expected),
    .test_id        (test_id),
    .window_end     (window_end),
    .pass_count     (pass_count),
    .fail_count     (fail_count)
  );

  always #20 clk = ~clk;                   // 40 ns period

  // sign 12, tens 11:8, units 7:4, tenths 3:0
  function automatic logic [15:0] format_positive(input int sixteenths);
    int whole;
    int tenths;
    whole  = sixteenths / 16;
    tenths = (sixteenths % 16) * 10 / 16;  // rounded down
    if (whole > 99)
      return 16'h0999;
    return {4'h0, 4'(whole / 10), 4'(whole % 10), 4'(tenths)};
  endfunction

  // ------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------
  task automatic fill_table();
    int r;
    table_rows[0] = '{16'h0191, 1'b1, 16'h0250};   // 25.0625
    table_rows[1] = '{16'h00A8, 1'b1, 16'h0105};   // 10.5
    table_rows[2] = '{16'hFF5E, 1'b1, 16'h1101};   // -10.125
    table_rows[3] = '{16'h07D0, 1'b1, 16'h0999};   // 125.0 clamps
    table_rows[4] = '{16'h0000, 1'b0, 16'h0000};   // device silent
    table_rows[5] = '{16'hFE6F, 1'b1, 16'h1250};   // -25.0625 after recovery
    for (int i = 6; i < NUM_ROWS; i++)
    begin
      r = $urandom % 1600;                 // 0 to 99.9375
      table_rows[i] = '{16'(r), 1'b1, format_positive(r)};
    end
  endtask

  task automatic wait_for_reading(output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      if (temp_valid)
        ok = 1'b1;
      cycles++;
    end
  endtask

  task automatic watch_quiet_window();
    repeat (WINDOW_CYCLES) @(negedge clk);
    window_end = 1'b1;
    @(negedge clk);
    window_end = 1'b0;
  endtask

  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    presence_en    = 1'b1;
    model_raw      = 16'h0000;
    expect_reading = 1'b0;
    expected       = 16'h0000;
    test_id        = 0;
    window_end     = 1'b0;
    timed_out      = 1'b0;
    got_reading    = 1'b0;
    void'($urandom(96009));
    fill_table();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ROWS && !timed_out; i++)
    begin
      @(negedge clk);
      test_id        = i;
      model_raw      = table_rows[i].raw;
      presence_en    = table_rows[i].presence;
      expected       = table_rows[i].expected;
      expect_reading = table_rows[i].presence;
      if (table_rows[i].presence)
      begin
        wait_for_reading(got_reading);
        if (!got_reading)
          timed_out = 1'b1;
      end
      else
        watch_quiet_window();
    end
    @(negedge clk);                        // checker takes the last reading

    if (timed_out)
      $display("test %0d: no temp_valid within %0d cycles", test_id, TIMEOUT_CYCLES);
    $display("passed %0d, failed %0d, command byte errors %0d",
             pass_count, fail_count, cmd_errors);
    if (timed_out || fail_count != 0 || cmd_errors != 0)
      $display("Regression failed");
    else
      $display("Regression passed");
    $finish;
  end

endmodule

/* verilog.f */
src/onewire_pkg.sv
src/onewire_slot_engine.sv
src/ds18b20_sequencer.sv
src/temp_formatter.sv
src/ds18b20_reader.sv
tb/ds18b20_model.sv
tb/reader_checker.sv
tb/reader_sva.sv
tb/tb_ds18b20_reader.sv

/* Makefile */
SIM      = verilator
TOP      = tb_ds18b20_reader
FILELIST = verilog.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@! grep -q "Regression failed" $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
